// ==== rv32i_exec.f ====
logic/rv32i_exec_pkg.sv
logic/inst_decoder.sv
logic/issue_buffer.sv
logic/exec_unit.sv
logic/rv32i_exec.sv
tests/rv32i_exec_props.sv
tests/rv32i_exec_checker.sv
tests/tb_rv32i_exec.sv

// ==== tests/tb_rv32i_exec.sv ====
`timescale 1ns/10ps

module tb_rv32i_exec import rv32i_exec_pkg::*; ();

	logic        clk;
	logic        rst_n_i;
	logic        in_valid_i;
	logic        in_ready_o;
	issue_t      in_data_i;
	logic        out_valid_o;
	logic        out_ready_i;
	result_t     out_data_o;
	logic [31:0] seed = 32'd79043;
	logic [31:0] bp_seed;
	logic        bp_mode = 1'b0;
	int          fails = 0;
	int          wait_limit = 2000;  // cycles per wait loop

	rv32i_exec UUT (.*);

	rv32i_exec_checker chk (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.in_valid_i  (in_valid_i),
		.in_ready_i  (in_ready_o),
		.in_data_i   (in_data_i),
		.out_valid_i (out_valid_o),
		.out_ready_i (out_ready_i),
		.out_data_i  (out_data_o)
	);

	bind rv32i_exec rv32i_exec_props u_props (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s ^= s << 13;
		s ^= s >> 17;
		s ^= s << 5;
		return s;
	endfunction

	function automatic logic [31:0] rnd();
		seed = xorshift(seed);
		return seed;
	endfunction

	// grp 0 arithmetic, 1 control flow, 2 illegal, 3 weighted mix
	function automatic logic [31:0] gen_inst(input int grp);
		logic [31:0] w;
		int          pick;
		w    = rnd();
		pick = rnd() % 6;
		if (grp == 3)
			grp = rnd() % 3;
		case (grp)
			0: begin
				w[6:0] = (pick < 3) ? OPC_OP_IMM : OPC_OP;
				if (pick >= 3 || w[13:12] == 2'b01)
					w[31:25] = {1'b0, w[30], 5'b00000};  // keep bit 30 for sub/sra
			end
			1: begin
				case (pick)
					0, 1: begin
						w[6:0] = OPC_BRANCH;
						if (w[14:13] == 2'b01)
							w[13] = 1'b0;  // avoid funct3 2 and 3
					end
					2: w[6:0] = OPC_JAL;
					3: begin
						w[6:0]   = OPC_JALR;
						w[14:12] = 3'b000;
					end
					4: w[6:0] = w[20] ? OPC_LUI : OPC_AUIPC;
					default: w[6:0] = OPC_FENCE;
				endcase
			end
			default: begin
				case (pick)
					0: w[6:0] = 7'b0000011;  // load
					1: w[6:0] = 7'b0100011;  // store
					2: w[6:0] = 7'b1110011;  // system
					3: begin
						w[6:0]   = OPC_OP;
						w[31:25] = 7'b0000001;  // mul/div
					end
					4: begin
						w[6:0] = OPC_OP;
						w[31]  = 1'b1;  // funct7 neither 0 nor 0x20
					end
					default: begin
						w[6:0]   = OPC_BRANCH;
						w[14:13] = 2'b01;
					end
				endcase
			end
		endcase
		return w;
	endfunction

	function automatic issue_t make_issue(input int grp);
		issue_t t;
		int     pick;
		t.inst     = gen_inst(grp);
		t.pc       = rnd() & 32'hffff_fffc;
		t.rs1_data = rnd();
		pick       = rnd() % 4;
		if (pick == 0)
			t.rs2_data = t.rs1_data;
		else if (pick == 1)
			t.rs2_data = t.rs1_data ^ 32'h8000_0000;  // differs only in sign
		else
			t.rs2_data = rnd();
		return t;
	endfunction

	// called at a falling edge, returns at a falling edge
	task automatic send(input issue_t t);
		int waited = 0;
		in_valid_i = 1'b1;
		in_data_i  = t;
		while (!in_ready_o && waited < wait_limit) begin
			@(negedge clk);
			waited++;
		end
		if (!in_ready_o) begin
			fails++;
			$display("timeout at %0t ns: in_ready_o stayed low", $time);
		end
		@(negedge clk);
		in_valid_i = 1'b0;
	endtask

	task automatic drain();
		int waited = 0;
		while (chk.pending != 0 && waited < wait_limit) begin
			@(negedge clk);
			waited++;
		end
		if (chk.pending != 0) begin
			fails++;
			$display("timeout: %0d accepted instructions produced no result", chk.pending);
		end
	endtask

	task automatic run_test(input string name, input int grp, input int n, input logic bp);
		int c0;
		int e0;
		c0      = chk.checked;
		e0      = chk.errors + fails;
		bp_mode = bp;
		repeat (n) send(make_issue(grp));
		drain();
		bp_mode = 1'b0;
		$display("%s: %0d results checked, %0d errors", name, chk.checked - c0,
			chk.errors + fails - e0);
	endtask

	always @(negedge clk) begin
		if (bp_mode) begin
			bp_seed     = xorshift(bp_seed);
			out_ready_i = bp_seed[7];
		end else begin
			out_ready_i = 1'b1;
		end
	end

	initial begin
		rst_n_i     = 1'b0;
		in_valid_i  = 1'b0;
		in_data_i   = '0;
		out_ready_i = 1'b1;
		bp_seed     = ~seed;  // separate stream for out_ready_i
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n_i = 1'b1;
		@(negedge clk);
		if (out_valid_o !== 1'b0) begin
			fails++;
			$display("[ERROR] %0t ns: out_valid_o expected 0 actual %b", $time, out_valid_o);
		end
		if (in_ready_o !== 1'b1) begin
			fails++;
			$display("[ERROR] %0t ns: in_ready_o expected 1 actual %b", $time, in_ready_o);
		end
		$display("reset: %0d errors", fails);

		run_test("arithmetic", 0, 200, 1'b0);
		run_test("control flow", 1, 200, 1'b0);
		run_test("illegal", 2, 60, 1'b0);
		run_test("back-pressure", 3, 300, 1'b1);

		fails += UUT.u_props.prop_fails;
		$display("%0d results checked, %0d errors", chk.checked, chk.errors + fails);
		if (chk.errors + fails == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// ==== tests/rv32i_exec_checker.sv ====
`timescale 1ns/10ps

module rv32i_exec_checker import rv32i_exec_pkg::*; (
	input logic    clk,
	input logic    rst_n_i,
	input logic    in_valid_i,
	input logic    in_ready_i,
	input issue_t  in_data_i,
	input logic    out_valid_i,
	input logic    out_ready_i,
	input result_t out_data_i
);

	issue_t  q[$];         // accepted and not yet retired
	result_t expd;
	logic    exp_ready;
	int      errors  = 0;
	int      checked = 0;
	int      pending = 0;

	function automatic logic less_signed(input logic [31:0] a, input logic [31:0] b);
		return (a[31] != b[31]) ? a[31] : (a < b);  // on mixed signs the negative is less
	endfunction

	function automatic result_t ref_result(input issue_t t);
		logic [6:0]  opc;
		logic [2:0]  f3;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] v;
		logic [31:0] npc;
		logic        ok;
		logic        we;
		logic        taken;
		result_t     r;
		opc   = t.inst[6:0];
		f3    = t.inst[14:12];
		a     = t.rs1_data;
		b     = t.rs2_data;
		imm_i = {{20{t.inst[31]}}, t.inst[31:20]};
		ok    = 1'b1;
		we    = 1'b1;
		v     = '0;
		npc   = t.pc + 32'd4;
		case (opc)
			OPC_OP_IMM, OPC_OP: begin
				if (opc == OPC_OP)
					ok = (t.inst[31:25] == 7'h00) || (t.inst[31:25] == 7'h20);
				else
					b = imm_i;
				case (f3)
					3'd0: v = (opc == OPC_OP && t.inst[30]) ? a - b : a + b;
					3'd1: v = a << b[4:0];
					3'd2: v = {31'b0, less_signed(a, b)};
					3'd3: v = {31'b0, a < b};
					3'd4: v = a ^ b;
					3'd5: begin
						v = a >> b[4:0];
						if (t.inst[30] && a[31])
							v = v | ~(32'hffff_ffff >> b[4:0]);  // sign fill
					end
					3'd6: v = a | b;
					default: v = a & b;
				endcase
			end
			OPC_LUI:   v = {t.inst[31:12], 12'h000};
			OPC_AUIPC: v = t.pc + {t.inst[31:12], 12'h000};
			OPC_JAL: begin
				v   = t.pc + 32'd4;
				npc = t.pc + {{12{t.inst[31]}}, t.inst[19:12], t.inst[20], t.inst[30:21], 1'b0};
			end
			OPC_JALR: begin
				v   = t.pc + 32'd4;
				npc = a + imm_i;
			end
			OPC_BRANCH: begin
				we = 1'b0;
				ok = (f3 != 3'd2) && (f3 != 3'd3);
				case (f3)
					3'd0: taken = (a == b);
					3'd1: taken = (a != b);
					3'd4: taken = less_signed(a, b);
					3'd5: taken = !less_signed(a, b);
					3'd6: taken = (a < b);
					default: taken = (a >= b);
				endcase
				if (taken)
					npc = t.pc + {{20{t.inst[31]}}, t.inst[7], t.inst[30:25], t.inst[11:8], 1'b0};
			end
			OPC_FENCE: we = 1'b0;
			default:   ok = 1'b0;
		endcase
		r.illegal  = !ok;
		r.rd_we    = ok && we;
		r.rd_addr  = r.rd_we ? t.inst[11:7] : 5'd0;
		r.rd_wdata = r.rd_we ? v : 32'h0;
		r.pc_next  = ok ? npc : 32'h0;
		return r;
	endfunction

	task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			errors++;
			$display("[ERROR] %0t ns: out_data_o.%s expected %h actual %h",
				$time, name, exp, act);
		end
	endtask

	always @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			q.delete();
			pending = 0;
		end else begin
			// q holds the two-entry buffer plus the one in the output register
			exp_ready = (q.size() - int'(out_valid_i)) < 2;
			if (in_ready_i !== exp_ready) begin
				errors++;
				$display("[ERROR] %0t ns: in_ready_o expected %b actual %b",
					$time, exp_ready, in_ready_i);
			end
			if (out_valid_i && out_ready_i) begin
				if (q.size() == 0) begin
					errors++;
					$display("a result left at %0t ns with no accepted instruction", $time);
				end else begin
					expd = ref_result(q.pop_front());
					checked++;
					check_field("rd_we", expd.rd_we, out_data_i.rd_we);
					check_field("rd_addr", expd.rd_addr, out_data_i.rd_addr);
					check_field("rd_wdata", expd.rd_wdata, out_data_i.rd_wdata);
					check_field("pc_next", expd.pc_next, out_data_i.pc_next);
					check_field("illegal", expd.illegal, out_data_i.illegal);
				end
			end
			if (in_valid_i && in_ready_i)
				q.push_back(in_data_i);
			pending = q.size();
		end
	end

endmodule

// ==== tests/rv32i_exec_props.sv ====
`timescale 1ns/10ps

module rv32i_exec_props import rv32i_exec_pkg::*; (
	input logic    clk,
	input logic    rst_n_i,
	input logic    out_valid_o,
	input logic    out_ready_i,
	input result_t out_data_o
);

	int prop_fails = 0;

	// covers the reset cycles and the first edge after release
	a_idle_in_reset: assert property (@(posedge clk) !rst_n_i |=> !out_valid_o)
		else begin
			prop_fails++;
			$error("out_valid_o high during or right after reset");
		end

	a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
		(out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_data_o)))
		else begin
			prop_fails++;
			$error("output changed while stalled");
		end

	a_illegal_clean: assert property (@(posedge clk) disable iff (!rst_n_i)
		(out_valid_o && out_data_o.illegal) |->
			(!out_data_o.rd_we && out_data_o.pc_next == '0))
		else begin
			prop_fails++;
			$error("illegal result with write enable or nonzero pc_next");
		end

endmodule

// ==== logic/rv32i_exec.sv ====
`timescale 1ns/10ps

module rv32i_exec import rv32i_exec_pkg::*; (
	input  logic    clk,
	input  logic    rst_n_i,
	input  logic    in_valid_i,
	output logic    in_ready_o,
	input  issue_t  in_data_i,
	output logic    out_valid_o,
	input  logic    out_ready_i,
	output result_t out_data_o
);

	micro_op_t dec_uop;    // decoder to buffer
	micro_op_t buf_uop;    // buffer to execute
	logic      buf_valid;
	logic      buf_ready;

	inst_decoder u_dec (
		.issue_i (in_data_i),
		.uop_o   (dec_uop)
	);

	issue_buffer u_buf (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.wr_valid_i (in_valid_i),
		.wr_ready_o (in_ready_o),
		.wr_data_i  (dec_uop),
		.rd_valid_o (buf_valid),
		.rd_ready_i (buf_ready),
		.rd_data_o  (buf_uop)
	);

	exec_unit u_exec (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.uop_valid_i (buf_valid),
		.uop_ready_o (buf_ready),
		.uop_i       (buf_uop),
		.res_valid_o (out_valid_o),
		.res_ready_i (out_ready_i),
		.res_o       (out_data_o)
	);

endmodule

// ==== logic/exec_unit.sv ====
`timescale 1ns/10ps

module exec_unit import rv32i_exec_pkg::*; (
	input  logic      clk,
	input  logic      rst_n_i,
	input  logic      uop_valid_i,
	output logic      uop_ready_o,
	input  micro_op_t uop_i,
	output logic      res_valid_o,
	input  logic      res_ready_i,
	output result_t   res_o
);

	logic [XLEN-1:0] alu_res;
	logic [4:0]      shamt;
	logic            cmp_eq;
	logic            cmp_ge_s;
	logic            cmp_ge_u;
	logic            br_taken;
	logic [XLEN-1:0] npc_base;
	logic [XLEN-1:0] npc_off;
	logic [XLEN-1:0] npc;
	result_t         res_d;

	assign shamt = uop_i.opb[4:0];

	always_comb begin
		case (uop_i.alu_op)
			ALU_ADD:    alu_res = uop_i.opa + uop_i.opb;
			ALU_SUB:    alu_res = uop_i.opa - uop_i.opb;
			ALU_SLL:    alu_res = uop_i.opa << shamt;
			ALU_SLT:    alu_res = XLEN'($signed(uop_i.opa) < $signed(uop_i.opb));
			ALU_SLTU:   alu_res = XLEN'(uop_i.opa < uop_i.opb);
			ALU_XOR:    alu_res = uop_i.opa ^ uop_i.opb;
			ALU_SRL:    alu_res = uop_i.opa >> shamt;
			ALU_SRA:    alu_res = $unsigned($signed(uop_i.opa) >>> shamt);
			ALU_OR:     alu_res = uop_i.opa | uop_i.opb;
			ALU_AND:    alu_res = uop_i.opa & uop_i.opb;
			ALU_PASS_B: alu_res = uop_i.opb;
			default:    alu_res = '0;
		endcase
	end

	// branch comparators on the raw register values
	assign cmp_eq   = (uop_i.rs1_data == uop_i.rs2_data);
	assign cmp_ge_s = ($signed(uop_i.rs1_data) >= $signed(uop_i.rs2_data));
	assign cmp_ge_u = (uop_i.rs1_data >= uop_i.rs2_data);

	always_comb begin
		case (uop_i.br_cond)
			BR_EQ:   br_taken = cmp_eq;
			BR_NE:   br_taken = !cmp_eq;
			BR_LT:   br_taken = !cmp_ge_s;
			BR_GE:   br_taken = cmp_ge_s;
			BR_LTU:  br_taken = !cmp_ge_u;
			BR_GEU:  br_taken = cmp_ge_u;
			default: br_taken = 1'b0;
		endcase
	end

	// second adder for the next pc
	always_comb begin
		npc_base = (uop_i.pc_sel == PC_JUMP_REG) ? uop_i.rs1_data : uop_i.pc;
		case (uop_i.pc_sel)
			PC_BRANCH:   npc_off = br_taken ? uop_i.imm : PC_STEP;
			PC_JUMP:     npc_off = uop_i.imm;
			PC_JUMP_REG: npc_off = uop_i.imm;
			default:     npc_off = PC_STEP;
		endcase
	end

	assign npc = npc_base + npc_off;

	always_comb begin
		res_d.rd_we    = uop_i.rd_we;
		res_d.rd_addr  = uop_i.rd_addr;
		res_d.rd_wdata = uop_i.rd_we ? alu_res : '0;
		res_d.pc_next  = uop_i.illegal ? '0 : npc;
		res_d.illegal  = uop_i.illegal;
	end

	// take a new entry when the output slot is empty or drains now
	assign uop_ready_o = !res_valid_o || res_ready_i;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			res_valid_o <= 1'b0;
		end else if (uop_valid_i && uop_ready_o) begin
			res_valid_o <= 1'b1;
		end else if (res_ready_i) begin
			res_valid_o <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (uop_valid_i && uop_ready_o) begin
			res_o <= res_d;  // held while stalled
		end
	end

endmodule

// ==== logic/issue_buffer.sv ====
`timescale 1ns/10ps

module issue_buffer import rv32i_exec_pkg::*; (
	input  logic      clk,
	input  logic      rst_n_i,
	input  logic      wr_valid_i,
	output logic      wr_ready_o,
	input  micro_op_t wr_data_i,
	output logic      rd_valid_o,
	input  logic      rd_ready_i,
	output micro_op_t rd_data_o
);

	micro_op_t  mem [2];
	logic       wr_ptr;
	logic       rd_ptr;
	logic [1:0] count;  // 0..2 entries
	logic       do_wr;
	logic       do_rd;

	assign wr_ready_o = (count != 2'd2);  // registered state only
	assign rd_valid_o = (count != 2'd0);
	assign rd_data_o  = mem[rd_ptr];

	assign do_wr = wr_valid_i && wr_ready_o;
	assign do_rd = rd_valid_o && rd_ready_i;

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data_i;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count  <= 2'd0;
		end else begin
			if (do_wr) begin
				wr_ptr <= ~wr_ptr;
			end
			if (do_rd) begin
				rd_ptr <= ~rd_ptr;
			end
			case ({do_wr, do_rd})
				2'b10:   count <= count + 2'd1;
				2'b01:   count <= count - 2'd1;
				default: count <= count;  // both or neither
			endcase
		end
	end

endmodule

// ==== logic/inst_decoder.sv ====
`timescale 1ns/10ps

module inst_decoder import rv32i_exec_pkg::*; (
	input  issue_t    issue_i,
	output micro_op_t uop_o
);

	logic [INST_W-1:0]     inst;
	opcode_e               opcode;
	logic [2:0]            funct3;
	logic [6:0]            funct7;
	logic [REG_ADDR_W-1:0] rd;
	logic [XLEN-1:0]       imm_i;
	logic [XLEN-1:0]       imm_b;
	logic [XLEN-1:0]       imm_u;
	logic [XLEN-1:0]       imm_j;

	assign inst   = issue_i.inst;
	assign opcode = opcode_e'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign rd     = inst[11:7];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'h000};
	assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		uop_o          = '0;
		uop_o.alu_op   = ALU_ADD;
		uop_o.pc_sel   = PC_SEQ;
		uop_o.br_cond  = BR_EQ;
		uop_o.opa      = issue_i.rs1_data;
		uop_o.opb      = imm_i;
		uop_o.rs1_data = issue_i.rs1_data;
		uop_o.rs2_data = issue_i.rs2_data;
		uop_o.pc       = issue_i.pc;
		uop_o.imm      = imm_i;

		case (opcode)
			OPC_OP_IMM: begin
				uop_o.rd_we = 1'b1;
				case (funct3)
					3'b000:  uop_o.alu_op = ALU_ADD;
					3'b001:  uop_o.alu_op = ALU_SLL;  // shamt sits in imm_i[4:0]
					3'b010:  uop_o.alu_op = ALU_SLT;
					3'b011:  uop_o.alu_op = ALU_SLTU;
					3'b100:  uop_o.alu_op = ALU_XOR;
					3'b101:  uop_o.alu_op = inst[30] ? ALU_SRA : ALU_SRL;
					3'b110:  uop_o.alu_op = ALU_OR;
					default: uop_o.alu_op = ALU_AND;
				endcase
			end
			OPC_OP: begin
				uop_o.opb   = issue_i.rs2_data;
				uop_o.rd_we = 1'b1;
				// M extension (funct7 = 1) lands here too
				uop_o.illegal = (funct7 != F7_BASE) && (funct7 != F7_ALT);
				case (funct3)
					3'b000:  uop_o.alu_op = inst[30] ? ALU_SUB : ALU_ADD;
					3'b001:  uop_o.alu_op = ALU_SLL;
					3'b010:  uop_o.alu_op = ALU_SLT;
					3'b011:  uop_o.alu_op = ALU_SLTU;
					3'b100:  uop_o.alu_op = ALU_XOR;
					3'b101:  uop_o.alu_op = inst[30] ? ALU_SRA : ALU_SRL;
					3'b110:  uop_o.alu_op = ALU_OR;
					default: uop_o.alu_op = ALU_AND;
				endcase
			end
			OPC_LUI: begin
				uop_o.alu_op = ALU_PASS_B;
				uop_o.opb    = imm_u;
				uop_o.rd_we  = 1'b1;
			end
			OPC_AUIPC: begin
				uop_o.opa   = issue_i.pc;
				uop_o.opb   = imm_u;
				uop_o.rd_we = 1'b1;
			end
			OPC_JAL: begin
				uop_o.opa    = issue_i.pc;  // link = pc + 4
				uop_o.opb    = PC_STEP;
				uop_o.rd_we  = 1'b1;
				uop_o.pc_sel = PC_JUMP;
				uop_o.imm    = imm_j;
			end
			OPC_JALR: begin
				uop_o.opa    = issue_i.pc;
				uop_o.opb    = PC_STEP;
				uop_o.rd_we  = 1'b1;
				uop_o.pc_sel = PC_JUMP_REG;
			end
			OPC_BRANCH: begin
				uop_o.pc_sel  = PC_BRANCH;
				uop_o.br_cond = br_cond_e'(funct3);
				uop_o.imm     = imm_b;
				uop_o.illegal = (funct3 == 3'b010) || (funct3 == 3'b011);
			end
			OPC_FENCE: begin
				uop_o.rd_we = 1'b0;  // no-op here, just step the pc
			end
			default: begin
				uop_o.illegal = 1'b1;  // loads, stores, system, unknown
			end
		endcase

		if (uop_o.illegal) begin
			uop_o.rd_we = 1'b0;
		end
		uop_o.rd_addr = uop_o.rd_we ? rd : '0;  // b-type bits 11:7 are not rd
	end

endmodule

// ==== logic/rv32i_exec_pkg.sv ====
package rv32i_exec_pkg;

	localparam int XLEN       = 32;                  // data and pc width
	localparam int REG_ADDR_W = 5;
	localparam int INST_W     = 32;

	localparam logic [XLEN-1:0] PC_STEP = XLEN'(4);  // sequential pc increment

	localparam logic [6:0] F7_BASE = 7'b0000000;     // plain OP
	localparam logic [6:0] F7_ALT  = 7'b0100000;     // sub / sra variant

	// major opcodes, only the groups this stage executes
	typedef enum logic [6:0] {
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_FENCE  = 7'b0001111
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_SLL    = 4'd2,
		ALU_SLT    = 4'd3,
		ALU_SLTU   = 4'd4,
		ALU_XOR    = 4'd5,
		ALU_SRL    = 4'd6,
		ALU_SRA    = 4'd7,
		ALU_OR     = 4'd8,
		ALU_AND    = 4'd9,
		ALU_PASS_B = 4'd10   // lui
	} alu_op_e;

	typedef enum logic [1:0] {
		PC_SEQ      = 2'd0,  // pc + 4
		PC_BRANCH   = 2'd1,  // pc + imm if taken
		PC_JUMP     = 2'd2,  // pc + imm
		PC_JUMP_REG = 2'd3   // rs1 + imm
	} pc_sel_e;

	// coded as the branch funct3
	typedef enum logic [2:0] {
		BR_EQ  = 3'b000,
		BR_NE  = 3'b001,
		BR_LT  = 3'b100,
		BR_GE  = 3'b101,
		BR_LTU = 3'b110,
		BR_GEU = 3'b111
	} br_cond_e;

	typedef struct packed {
		logic [INST_W-1:0] inst;
		logic [XLEN-1:0]   pc;
		logic [XLEN-1:0]   rs1_data;
		logic [XLEN-1:0]   rs2_data;
	} issue_t;

	typedef struct packed {
		alu_op_e               alu_op;
		pc_sel_e               pc_sel;
		br_cond_e              br_cond;
		logic [XLEN-1:0]       opa;       // alu operand a
		logic [XLEN-1:0]       opb;       // alu operand b
		logic [XLEN-1:0]       rs1_data;  // compare and jalr base
		logic [XLEN-1:0]       rs2_data;
		logic [XLEN-1:0]       pc;
		logic [XLEN-1:0]       imm;       // next-pc offset
		logic [REG_ADDR_W-1:0] rd_addr;
		logic                  rd_we;
		logic                  illegal;
	} micro_op_t;

	typedef struct packed {
		logic                  rd_we;
		logic [REG_ADDR_W-1:0] rd_addr;
		logic [XLEN-1:0]       rd_wdata;
		logic [XLEN-1:0]       pc_next;
		logic                  illegal;
	} result_t;

endpackage
